// ==== dcache.f ====
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_ram.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache.sv
bench/mem_model.sv
bench/dcache_assert.sv
bench/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator

rm -f sim.log
verilator --binary --timing -Wno-fatal -f dcache.f --top-module tb_dcache -o sim_dcache \
    > build.log 2>&1 &&
./obj_dir/sim_dcache > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    // at most eight misses of under 150 cycles each, plus the hit traffic
    localparam int miss_count = 8;
    localparam int max_cycles = miss_count * 150 + 400;

    logic        clk;
    logic        resetn;
    logic        req_valid;
    logic [31:0] req_addr;
    strobe_t     req_strobe;
    word_t       req_wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        mem_valid;
    logic        mem_is_write;
    logic [31:0] mem_addr;
    word_t       mem_wdata;
    logic        mem_ready;
    word_t       mem_rdata;
    logic        mem_last;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'h1397;

    bit [7:0]    shadow [bit [31:0]];
    logic [31:0] addr_q [$];
    strobe_t     strobe_q [$];
    word_t       wdata_q [$];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    dcache i_dcache (
        .clk(clk), .resetn(resetn),
        .req_valid(req_valid), .req_addr(req_addr), .req_strobe(req_strobe),
        .req_wdata(req_wdata), .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .mem_valid(mem_valid), .mem_is_write(mem_is_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .mem_last(mem_last)
    );

    mem_model i_mem (
        .clk(clk), .resetn(resetn),
        .mem_valid(mem_valid), .mem_is_write(mem_is_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .mem_last(mem_last)
    );

    bind dcache dcache_assert i_dcache_assert (
        .clk(clk), .resetn(resetn), .req_valid(req_valid), .addr_ok(addr_ok),
        .data_ok(data_ok), .mem_valid(mem_valid), .mem_ready(mem_ready),
        .mem_last(mem_last), .mem_addr(mem_addr)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hc3;
    endfunction

    function automatic word_t shadow_word(input logic [31:0] a);
        word_t w;
        for (int b = 0; b < byte_per_word; b++) begin
            w[8*b +: 8] = shadow.exists(a + b) ? shadow[a + b] : pattern_byte(a + b);
        end
        return w;
    endfunction

    task automatic apply_write(input logic [31:0] a, input strobe_t s, input word_t d);
        for (int b = 0; b < byte_per_word; b++) begin
            if (s[b]) begin
                shadow[a + b] = d[8*b +: 8];
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_request(input logic [31:0] a, input strobe_t s, input word_t d);
        addr_q.push_back({a[31:2], 2'b00});
        strobe_q.push_back(s);
        wdata_q.push_back(d);
    endtask

    // issues the queued requests back to back, checks each data_ok in order
    task automatic run_requests(input bit no_stall);
        int    n;
        int    idx;
        int    done;
        int    stalls;
        word_t exp_q [$];
        n = addr_q.size();
        idx = 0;
        done = 0;
        stalls = 0;
        while (done < n) begin
            @(posedge clk);
            if (req_valid && addr_ok) begin
                exp_q.push_back(shadow_word(req_addr));
                apply_write(req_addr, req_strobe, req_wdata);
                idx++;
            end else if (req_valid) begin
                stalls++;
            end
            if (data_ok) begin
                if (exp_q.size() == 0) begin
                    $display("data_ok at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    check_value("rdata", rdata, exp_q.pop_front());
                end
                done++;
            end
            if (idx < n) begin
                req_valid  <= 1'b1;
                req_addr   <= addr_q[idx];
                req_strobe <= strobe_q[idx];
                req_wdata  <= wdata_q[idx];
            end else begin
                req_valid <= 1'b0;
            end
        end
        if (no_stall && stalls != 0) begin
            $display("request stalled %0d cycles where hits were expected", stalls);
            errors++;
        end
        addr_q.delete();
        strobe_q.delete();
        wdata_q.delete();
    endtask

    task automatic cold_read();
        int f0;
        f0 = i_mem.fetch_count;
        add_request(32'h0000_0100, 4'b0000, '0);
        run_requests(1'b0);
        check_value("fetch bursts", i_mem.fetch_count - f0, 1);
        add_request(32'h0000_013c, 4'b0000, '0);
        run_requests(1'b0);
        check_value("fetch bursts", i_mem.fetch_count - f0, 1);
    endtask

    task automatic write_then_read();
        add_request(32'h0000_0108, 4'b0101, 32'hdead_beef);
        add_request(32'h0000_0108, 4'b0000, '0);
        run_requests(1'b1);
    endtask

    task automatic dirty_evict();
        logic [31:0] a;
        int          w0;
        a = 32'h0001_0040;
        add_request(a + 8, 4'b1111, 32'h1234_5678);
        add_request(a + 32'h3c, 4'b1100, 32'habcd_0000);
        run_requests(1'b0);
        add_request(a + 32'h2000, 4'b0000, '0);
        run_requests(1'b0);
        w0 = i_mem.wb_count;
        add_request(a + 32'h4000, 4'b0000, '0);
        run_requests(1'b0);
        check_value("writeback bursts", i_mem.wb_count - w0, 1);
        check_value("wb_addr", i_mem.wb_addr, a);
        for (int i = 0; i < 16; i++) begin
            check_value("wb_data", i_mem.wb_data[i], shadow_word(a + 4 * i));
        end
        add_request(a + 8, 4'b0000, '0);
        run_requests(1'b0);
    endtask

    task automatic lru_order();
        logic [31:0] d;
        int          f0;
        d = 32'h0000_0080;
        add_request(d, 4'b0000, '0);
        run_requests(1'b0);
        add_request(d + 32'h2000, 4'b0000, '0);
        run_requests(1'b0);
        add_request(d + 4, 4'b0000, '0);
        run_requests(1'b0);
        add_request(d + 32'h4000, 4'b0000, '0);
        run_requests(1'b0);
        f0 = i_mem.fetch_count;
        add_request(d + 8, 4'b0000, '0);
        run_requests(1'b0);
        check_value("fetch bursts", i_mem.fetch_count - f0, 0);
    endtask

    task automatic random_hits();
        logic [31:0] lines [5];
        logic [31:0] r;
        int          f0;
        lines = '{32'h0000_0100, 32'h0001_0040, 32'h0001_4040,
                  32'h0000_0080, 32'h0000_4080};
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            r = rng;
            rng = xorshift32(rng);
            add_request(lines[r % 5] + {26'd0, r[11:8], 2'b00},
                        r[16] ? r[20:17] : 4'b0000, rng);
        end
        f0 = i_mem.fetch_count;
        run_requests(1'b1);
        check_value("fetch bursts", i_mem.fetch_count - f0, 0);
    endtask

    initial begin
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_strobe = '0;
        req_wdata  = '0;
        repeat (4) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);
        cold_read();
        write_then_read();
        dirty_evict();
        lru_order();
        random_hits();
        repeat (4) @(posedge clk);
        $display("finished with %0d errors and %0d assertion failures",
                 errors, i_dcache.i_dcache_assert.fail_count);
        if (errors == 0 && i_dcache.i_dcache_assert.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/dcache_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_assert (
    input logic        clk,
    input logic        resetn,
    input logic        req_valid,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        mem_valid,
    input logic        mem_ready,
    input logic        mem_last,
    input logic [31:0] mem_addr
);

    // accepted requests still waiting for data_ok
    logic [1:0] pending;

    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (resetn) begin
            pending <= '0;
        end else begin
            pending <= pending + {1'b0, req_valid && addr_ok} - {1'b0, data_ok};
        end
    end

    burst_held: assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !(mem_ready && mem_last) |=> mem_valid && $stable(mem_addr))
        else begin
            fail_count++;
            $error("mem_valid or mem_addr changed inside a burst");
        end

    data_ok_after_accept: assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> pending != 2'd0)
        else begin
            fail_count++;
            $error("data_ok without an accepted request");
        end

    // the missing request stays the only one outstanding
    no_accept_in_burst: assert property (@(posedge clk) disable iff (resetn)
        mem_valid |-> !addr_ok && pending == 2'd1)
        else begin
            fail_count++;
            $error("addr_ok high or a second request outstanding during a memory burst");
        end

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_model (
    input  logic              clk,
    input  logic              resetn,
    input  logic              mem_valid,
    input  logic              mem_is_write,
    input  logic [31:0]       mem_addr,
    input  dcache_pkg::word_t mem_wdata,
    output logic              mem_ready,
    output dcache_pkg::word_t mem_rdata,
    output logic              mem_last
);
    import dcache_pkg::*;

    bit [7:0] mem [bit [31:0]];

    int          fetch_count = 0;
    int          wb_count = 0;
    logic [31:0] wb_addr;
    word_t       wb_data [16];

    logic [31:0] rng;
    logic [3:0]  beat;
    logic [3:0]  next_beat;
    logic [31:0] r;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched bytes follow a pattern of the full address
    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hc3;
    endfunction

    function automatic word_t read_word(input logic [31:0] a);
        word_t w;
        for (int b = 0; b < byte_per_word; b++) begin
            w[8*b +: 8] = mem.exists(a + b) ? mem[a + b] : pattern_byte(a + b);
        end
        return w;
    endfunction

    // data for the next beat is staged one edge ahead
    always @(posedge clk) begin
        if (resetn) begin
            mem_ready <= 1'b0;
            mem_last  <= 1'b0;
            mem_rdata <= '0;
            beat      <= '0;
            rng       <= 32'h1397;
        end else begin
            next_beat = beat;
            r = xorshift32(rng);
            rng <= r;
            if (mem_valid && mem_ready) begin
                if (mem_is_write) begin
                    for (int b = 0; b < byte_per_word; b++) begin
                        mem[mem_addr + {26'd0, beat, 2'b00} + b] = mem_wdata[8*b +: 8];
                    end
                    wb_data[beat] <= mem_wdata;
                end
                if (mem_last) begin
                    next_beat = '0;
                    if (mem_is_write) begin
                        wb_count <= wb_count + 1;
                        wb_addr  <= mem_addr;
                    end else begin
                        fetch_count <= fetch_count + 1;
                    end
                end else begin
                    next_beat = beat + 4'd1;
                end
            end
            beat      <= next_beat;
            // one idle cycle after each burst so the address can move
            mem_ready <= mem_valid && !(mem_ready && mem_last) && (r[1:0] != 2'b00);
            mem_rdata <= read_word(mem_addr + {26'd0, next_beat, 2'b00});
            mem_last  <= (next_beat == 4'd15);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache #(
    parameter int set_num = 128,
    parameter int words_per_line = 16
) (
    input  logic                clk,
    input  logic                resetn,

    input  logic                req_valid,
    input  logic [31:0]         req_addr,
    input  dcache_pkg::strobe_t req_strobe,
    input  dcache_pkg::word_t   req_wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,

    output logic                mem_valid,
    output logic                mem_is_write,
    output logic [31:0]         mem_addr,
    output dcache_pkg::word_t   mem_wdata,
    input  logic                mem_ready,
    input  dcache_pkg::word_t   mem_rdata,
    input  logic                mem_last
);
    import dcache_pkg::*;

    localparam int index_bits = $clog2(set_num);
    localparam int offset_bits = $clog2(words_per_line);
    localparam int align_bits = $clog2(byte_per_word);
    localparam int tag_bits = addr_width - index_bits - offset_bits - align_bits;
    localparam int ram_depth = 2 * set_num * words_per_line;
    localparam int ram_addr_bits = $clog2(ram_depth);

    // stage 2 request
    logic        s2_valid;
    logic [31:0] s2_addr;
    strobe_t     s2_strobe;
    word_t       s2_wdata;

    logic                hit;
    logic                hit_way;
    logic                victim_way;
    logic                victim_dirty;
    logic [tag_bits-1:0] victim_tag;
    logic                miss;

    logic busy;
    logic fill_en;
    logic fill_way;
    logic refill_done;

    logic [ram_addr_bits-1:0] addr_a;
    logic                     en_b;
    strobe_t                  strobe_b;
    logic [ram_addr_bits-1:0] addr_b;
    word_t                    wdata_b;
    word_t                    rdata_b;

    // tag update in the refill_done cycle, replay as a hit after it
    assign miss    = s2_valid && !hit && !refill_done;
    assign addr_ok = !busy && !refill_done && !(s2_valid && !hit);
    assign addr_a  = {hit_way, s2_addr[offset_bits + align_bits +: index_bits],
                      s2_addr[align_bits +: offset_bits]};

    always_ff @(posedge clk) begin
        if (resetn) begin
            s2_valid <= 1'b0;
        end else if (addr_ok) begin
            s2_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok && req_valid) begin
            s2_addr   <= req_addr;
            s2_strobe <= req_strobe;
            s2_wdata  <= req_wdata;
        end
    end

    // read data leaves the ram one cycle after the hit
    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= hit;
        end
    end

    dcache_tag_array #(
        .set_num        (set_num),
        .words_per_line (words_per_line)
    ) i_tag_array (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_addr  (s2_addr),
        .lookup_valid (s2_valid),
        .lookup_write (|s2_strobe),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .fill_en      (fill_en),
        .fill_way     (fill_way)
    );

    dcache_data_ram #(
        .depth (ram_depth)
    ) i_data_ram (
        .clk      (clk),
        .en_a     (hit),
        .strobe_a (s2_strobe),
        .addr_a   (addr_a),
        .wdata_a  (s2_wdata),
        .rdata_a  (rdata),
        .en_b     (en_b),
        .strobe_b (strobe_b),
        .addr_b   (addr_b),
        .wdata_b  (wdata_b),
        .rdata_b  (rdata_b)
    );

    dcache_miss_ctrl #(
        .set_num        (set_num),
        .words_per_line (words_per_line)
    ) i_miss_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .miss         (miss),
        .miss_addr    (s2_addr),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .en_b         (en_b),
        .strobe_b     (strobe_b),
        .addr_b       (addr_b),
        .wdata_b      (wdata_b),
        .rdata_b      (rdata_b),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last),
        .busy         (busy),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .refill_done  (refill_done)
    );

endmodule

`default_nettype wire

// ==== verilog/dcache_miss_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_miss_ctrl #(
    parameter int set_num = 128,
    parameter int words_per_line = 16,
    localparam int index_bits = $clog2(set_num),
    localparam int offset_bits = $clog2(words_per_line),
    localparam int align_bits = $clog2(dcache_pkg::byte_per_word),
    localparam int tag_bits = dcache_pkg::addr_width - index_bits - offset_bits - align_bits,
    localparam int ram_addr_bits = 1 + index_bits + offset_bits
) (
    input  logic                     clk,
    input  logic                     resetn,

    input  logic                     miss,
    input  logic [31:0]              miss_addr,
    input  logic                     victim_way,
    input  logic                     victim_dirty,
    input  logic [tag_bits-1:0]      victim_tag,

    output logic                     en_b,
    output dcache_pkg::strobe_t      strobe_b,
    output logic [ram_addr_bits-1:0] addr_b,
    output dcache_pkg::word_t        wdata_b,
    input  dcache_pkg::word_t        rdata_b,

    output logic                     mem_valid,
    output logic                     mem_is_write,
    output logic [31:0]              mem_addr,
    output dcache_pkg::word_t        mem_wdata,
    input  logic                     mem_ready,
    input  dcache_pkg::word_t        mem_rdata,
    input  logic                     mem_last,

    output logic                     busy,
    output logic                     fill_en,
    output logic                     fill_way,
    output logic                     refill_done
);
    import dcache_pkg::*;

    miss_state_t state;

    logic                  way_q;
    logic [index_bits-1:0] index_q;
    logic [tag_bits-1:0]   tag_q;
    logic [tag_bits-1:0]   victim_tag_q;

    // msb set once all reads of the line are issued
    logic [offset_bits:0]   rd_cnt;
    logic                   rd_valid;
    logic [offset_bits-1:0] rd_idx;
    logic [offset_bits-1:0] send_cnt;
    logic [offset_bits-1:0] fetch_cnt;

    word_t buffer [words_per_line];

    logic [tag_bits-1:0] line_tag;

    assign busy        = (state != idle);
    assign fill_en     = refill_done;
    assign fill_way    = way_q;

    assign mem_valid    = (state == wb_send) || (state == fetch);
    assign mem_is_write = (state == wb_send);
    assign line_tag     = (state == wb_send) ? victim_tag_q : tag_q;
    assign mem_addr     = {line_tag, index_q, {(offset_bits + align_bits){1'b0}}};
    assign mem_wdata    = buffer[send_cnt];

    assign wdata_b = mem_rdata;

    always_comb begin
        en_b     = 1'b0;
        strobe_b = '0;
        addr_b   = {way_q, index_q, rd_cnt[offset_bits-1:0]};
        case (state)
            wb_read: begin
                en_b = ~rd_cnt[offset_bits];
            end
            fetch: begin
                en_b     = mem_ready;
                strobe_b = '1;
                addr_b   = {way_q, index_q, fetch_cnt};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state       <= idle;
            refill_done <= 1'b0;
            rd_cnt      <= '0;
            rd_valid    <= 1'b0;
            send_cnt    <= '0;
            fetch_cnt   <= '0;
        end else begin
            refill_done <= 1'b0;
            case (state)
                idle: begin
                    if (miss) begin
                        state     <= victim_dirty ? wb_read : fetch;
                        rd_cnt    <= '0;
                        rd_valid  <= 1'b0;
                        send_cnt  <= '0;
                        fetch_cnt <= '0;
                    end
                end
                wb_read: begin
                    if (!rd_cnt[offset_bits]) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    rd_valid <= ~rd_cnt[offset_bits];
                    // last word lands one cycle after its read
                    if (rd_valid && rd_idx == '1) begin
                        state <= wb_send;
                    end
                end
                wb_send: begin
                    if (mem_ready) begin
                        send_cnt <= send_cnt + 1'b1;
                        if (mem_last) begin
                            state <= fetch;
                        end
                    end
                end
                fetch: begin
                    if (mem_ready) begin
                        fetch_cnt <= fetch_cnt + 1'b1;
                        if (mem_last) begin
                            state       <= idle;
                            refill_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && miss) begin
            way_q        <= victim_way;
            victim_tag_q <= victim_tag;
            index_q      <= miss_addr[offset_bits + align_bits +: index_bits];
            tag_q        <= miss_addr[offset_bits + align_bits + index_bits +: tag_bits];
        end
        rd_idx <= rd_cnt[offset_bits-1:0];
        if (rd_valid) begin
            buffer[rd_idx] <= rdata_b;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_data_ram #(
    parameter int depth = 4096,
    localparam int addr_bits = $clog2(depth)
) (
    input  logic                clk,

    input  logic                en_a,
    input  dcache_pkg::strobe_t strobe_a,
    input  logic [addr_bits-1:0] addr_a,
    input  dcache_pkg::word_t   wdata_a,
    output dcache_pkg::word_t   rdata_a,

    input  logic                en_b,
    input  dcache_pkg::strobe_t strobe_b,
    input  logic [addr_bits-1:0] addr_b,
    input  dcache_pkg::word_t   wdata_b,
    output dcache_pkg::word_t   rdata_b
);
    import dcache_pkg::*;

    word_t mem [depth];

    // read-first on both ports
    always_ff @(posedge clk) begin
        if (en_a) begin
            for (int b = 0; b < byte_per_word; b++) begin
                if (strobe_a[b]) begin
                    mem[addr_a][8*b +: 8] <= wdata_a[8*b +: 8];
                end
            end
            rdata_a <= mem[addr_a];
        end
        if (en_b) begin
            for (int b = 0; b < byte_per_word; b++) begin
                if (strobe_b[b]) begin
                    mem[addr_b][8*b +: 8] <= wdata_b[8*b +: 8];
                end
            end
            rdata_b <= mem[addr_b];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array #(
    parameter int set_num = 128,
    parameter int words_per_line = 16,
    localparam int index_bits = $clog2(set_num),
    localparam int offset_bits = $clog2(words_per_line),
    localparam int align_bits = $clog2(dcache_pkg::byte_per_word),
    localparam int tag_bits = dcache_pkg::addr_width - index_bits - offset_bits - align_bits
) (
    input  logic                clk,
    input  logic                resetn,

    input  logic [31:0]         lookup_addr,
    input  logic                lookup_valid,
    input  logic                lookup_write,

    output logic                hit,
    output logic                hit_way,
    output logic                victim_way,
    output logic                victim_dirty,
    output logic [tag_bits-1:0] victim_tag,

    input  logic                fill_en,
    input  logic                fill_way
);

    localparam int index_lsb = offset_bits + align_bits;

    logic [1:0]          valid_q [set_num];
    logic [1:0]          dirty_q [set_num];
    logic [tag_bits-1:0] tag_q [2][set_num];
    // one bit per set, names the way to replace next
    logic [set_num-1:0]  lru_q;

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic [1:0]            match;

    assign index = lookup_addr[index_lsb +: index_bits];
    assign tag   = lookup_addr[index_lsb + index_bits +: tag_bits];

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign match[w] = valid_q[index][w] && (tag_q[w][index] == tag);
    end

    assign hit     = lookup_valid && (|match);
    assign hit_way = match[1];

    assign victim_way   = lru_q[index];
    assign victim_dirty = dirty_q[index][victim_way] && valid_q[index][victim_way];
    assign victim_tag   = tag_q[victim_way][index];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < set_num; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else if (fill_en) begin
            valid_q[index][fill_way] <= 1'b1;
            dirty_q[index][fill_way] <= 1'b0;
            lru_q[index]             <= ~fill_way;
        end else if (hit) begin
            lru_q[index] <= ~hit_way;
            if (lookup_write) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
        end
    end

    // new tag comes from the stalled stage-2 address
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_way][index] <= tag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // byte address width on both sides
    localparam int addr_width = 32;

    localparam int byte_per_word = 4;

    typedef logic [8*byte_per_word-1:0] word_t;

    // all zero means a read
    typedef logic [byte_per_word-1:0] strobe_t;

    // wb_read copies the victim line into the buffer, wb_send bursts it out
    typedef enum logic [1:0] {
        idle,
        wb_read,
        wb_send,
        fetch
    } miss_state_t;

endpackage

`default_nettype wire
